// File: filelist.f
+incdir+source
source/apple_mem_pkg.sv
source/soft_switches.sv
source/shadow_write_decode.sv
source/shadow_ram.sv
source/video_shadow.sv
source/keyboard_latch.sv
source/apple_memory.sv
verification/tb_clock_gen.sv
verification/apple_memory_props.sv
verification/apple_memory_tb.sv

// File: verification/apple_memory_tb.sv
`timescale 1ns/1ps
`include "apple_mem_settings.svh"

module apple_memory_tb;
    import apple_mem_pkg::*;

    localparam int WAIT_LIMIT = 16;

    logic        a2bus_if;
    logic        rst_i;
    a2_bus_t     bus;
    a2_addr_t    video_addr;
    ram_word_t   video_data;
    sw_ii_t      sw_ii;
    sw_iie_t     sw_iie;
    slot_t       slotrom;
    logic        intc8rom;
    logic        aux_mem;
    a2_data_t    keycode;
    logic        keypress_strobe;
    logic        last_aux_mem;
    logic [31:0] lcg_state;
    int          value_errors;
    int          other_errors;

    tb_clock_gen clock_gen_i (
        .clk_o (a2bus_if),
        .rst_o (rst_i)
    );

    apple_memory dut_i (
        .a2bus_if          (a2bus_if),
        .rst_i             (rst_i),
        .bus_i             (bus),
        .video_addr_i      (video_addr),
        .video_data_o      (video_data),
        .sw_ii_o           (sw_ii),
        .sw_iie_o          (sw_iie),
        .slotrom_o         (slotrom),
        .intc8rom_o        (intc8rom),
        .aux_mem_o         (aux_mem),
        .keycode_o         (keycode),
        .keypress_strobe_o (keypress_strobe)
    );

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    function automatic a2_bus_t idle_bus();
        a2_bus_t b;
        b = '0;
        b.rw_n = 1'b1;
        b.m2sel_n = 1'b1;
        return b;
    endfunction

    task automatic finish_run();
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic check_byte(input string name, input a2_data_t got, input a2_data_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input ram_word_t got, input ram_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ii(input string name, input sw_ii_t got, input sw_ii_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_iie(input string name, input sw_iie_t got, input sw_iie_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_slot(input string name, input slot_t got, input slot_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // One bus cycle: phi1 clock with the address, then the data strobe clock
    task automatic bus_access(input a2_addr_t addr, input a2_data_t data, input logic rw_n,
                              input logic m2b0);
        a2_bus_t b;
        b = idle_bus();
        b.addr = addr;
        b.data = data;
        b.rw_n = rw_n;
        b.m2b0 = m2b0;
        b.m2sel_n = 1'b0;
        b.phi1_posedge = 1'b1;
        @(posedge a2bus_if);
        bus <= b;
        b.phi1_posedge = 1'b0;
        b.data_in_strobe = 1'b1;
        @(posedge a2bus_if);
        bus <= b;
        @(negedge a2bus_if);
        last_aux_mem = aux_mem;
        @(posedge a2bus_if);
        bus <= idle_bus();
    endtask

    task automatic set_switch(input a2_addr_t addr);
        bus_access(addr, 8'h00, 1'b0, 1'b0);
    endtask

    task automatic write_byte(input a2_addr_t addr, input a2_data_t data, input logic m2b0,
                              input logic exp_aux);
        bus_access(addr, data, 1'b0, m2b0);
        check_bit("aux_mem_o", last_aux_mem, exp_aux);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_i !== 1'b0 && cycles < WAIT_LIMIT) begin
            @(negedge a2bus_if);
            cycles++;
        end
        if (rst_i !== 1'b0) begin
            other_errors++;
            $display("ERROR: reset was not released within %0d cycles", WAIT_LIMIT);
            finish_run();
        end
    endtask

    task automatic wait_keypress();
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge a2bus_if);
            seen = (keypress_strobe === 1'b1);
            cycles++;
        end
        if (!seen) begin
            other_errors++;
            $display("ERROR: no keypress strobe within %0d cycles of a key read", WAIT_LIMIT);
            finish_run();
        end
    endtask

    task automatic count_strobes(input int cycles, output int pulses);
        pulses = 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge a2bus_if);
            if (keypress_strobe !== 1'b0) begin
                pulses++;
            end
        end
    endtask

    // STORE80, RAMRD, RAMWRT, INTCXROM, ALTZP, SLOTC3ROM, PAGE2 and HIRES off
    task automatic clear_switches();
        set_switch(16'hC000);
        set_switch(16'hC002);
        set_switch(16'hC004);
        set_switch(16'hC006);
        set_switch(16'hC008);
        set_switch(16'hC00A);
        set_switch(16'hC054);
        set_switch(16'hC056);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic test_reset_state();
        @(negedge a2bus_if);
        check_ii("sw_ii_o", sw_ii, sw_ii_t'(`SW_II_RESET));
        check_iie("sw_iie_o", sw_iie, sw_iie_t'(8'h00));
        check_slot("slotrom_o", slotrom, 3'd0);
        check_bit("intc8rom_o", intc8rom, 1'b0);
    endtask

    task automatic test_switches();
        logic [7:0]  ii_bits;
        logic [7:0]  iie_bits;
        logic [31:0] r;
        a2_addr_t    addr;
        ii_bits = `SW_II_RESET;
        iie_bits = 8'h00;
        // Any access at $C05x, read or write
        for (int i = 0; i < 12; i++) begin
            r = next_random();
            addr = {12'hC05, r[3:0]};
            bus_access(addr, r[15:8], r[16], 1'b0);
            ii_bits[addr[3:1]] = addr[0];
            @(negedge a2bus_if);
            check_ii("sw_ii_o", sw_ii, sw_ii_t'(ii_bits));
        end
        for (int i = 0; i < 12; i++) begin
            r = next_random();
            addr = {12'hC00, r[3:0]};
            bus_access(addr, r[15:8], 1'b0, 1'b0);
            iie_bits[addr[3:1]] = addr[0];
            @(negedge a2bus_if);
            check_iie("sw_iie_o", sw_iie, sw_iie_t'(iie_bits));
        end
        // Reads leave the IIe switches alone, data kept low to spare the keyboard
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            bus_access({12'hC00, r[3:0]}, 8'h00, 1'b1, 1'b0);
            @(negedge a2bus_if);
            check_iie("sw_iie_o", sw_iie, sw_iie_t'(iie_bits));
        end
        r = next_random();
        bus_access(`A2_STATE_ADDR, r[7:0], 1'b0, 1'b0);
        ii_bits[2] = r[6];
        iie_bits[1] = r[5];
        iie_bits[2] = r[4];
        iie_bits[3] = r[0];
        @(negedge a2bus_if);
        check_ii("sw_ii_o", sw_ii, sw_ii_t'(ii_bits));
        check_iie("sw_iie_o", sw_iie, sw_iie_t'(iie_bits));
    endtask

    task automatic test_slot_rom();
        logic [31:0] r;
        r = next_random();
        bus_access({8'hC5, r[7:0]}, r[15:8], 1'b1, 1'b0);
        @(negedge a2bus_if);
        check_slot("slotrom_o", slotrom, 3'd5);
        check_bit("intc8rom_o", intc8rom, 1'b0);
        bus_access({8'hC3, r[23:16]}, r[15:8], 1'b1, 1'b0);
        @(negedge a2bus_if);
        check_slot("slotrom_o", slotrom, 3'd3);
        check_bit("intc8rom_o", intc8rom, 1'b1);
        bus_access(`A2_CFFF_ADDR, r[15:8], 1'b1, 1'b0);
        @(negedge a2bus_if);
        check_slot("slotrom_o", slotrom, 3'd0);
        check_bit("intc8rom_o", intc8rom, 1'b0);
    endtask

    task automatic test_text();
        logic [31:0] r;
        a2_addr_t    base;
        a2_data_t    main_even;
        a2_data_t    main_odd;
        a2_data_t    aux_even;
        a2_data_t    aux_odd;
        r = next_random();
        base = 16'h0400 + {5'b0, r[10:1], 1'b0};
        main_even = r[23:16];
        main_odd = r[31:24];
        r = next_random();
        aux_even = r[7:0];
        aux_odd = r[15:8];
        write_byte(base, main_even, 1'b0, 1'b0);
        write_byte(base + 16'd1, main_odd, 1'b0, 1'b0);
        set_switch(16'hC005);
        write_byte(base, aux_even, 1'b0, 1'b1);
        write_byte(base + 16'd1, aux_odd, 1'b0, 1'b1);
        set_switch(16'hC004);
        // Either byte of the pair reads the same word
        @(posedge a2bus_if);
        video_addr <= base + {15'b0, r[16]};
        @(posedge a2bus_if);
        @(negedge a2bus_if);
        check_word("video_data_o", video_data, {aux_odd, main_odd, aux_even, main_even});
    endtask

    task automatic test_hires();
        logic [31:0] r;
        logic [31:0] byte_r;
        a2_addr_t    base;
        a2_data_t    main_b [4];
        a2_data_t    aux_b [4];
        r = next_random();
        base = {3'b001, r[12:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            byte_r = next_random();
            main_b[i] = byte_r[7:0];
            aux_b[i] = byte_r[15:8];
            write_byte(base + 16'(i), main_b[i], 1'b0, 1'b0);
        end
        // Bytes 0 and 1 reach aux through the 80-column page switches
        set_switch(16'hC001);
        set_switch(16'hC055);
        set_switch(16'hC057);
        write_byte(base, aux_b[0], 1'b0, 1'b1);
        write_byte(base + 16'd1, aux_b[1], 1'b0, 1'b1);
        clear_switches();
        write_byte(base + 16'd2, aux_b[2], 1'b1, 1'b0);
        write_byte(base + 16'd3, aux_b[3], 1'b1, 1'b0);
        // Back to back scanner reads, one address per cycle
        @(posedge a2bus_if);
        video_addr <= base;
        @(posedge a2bus_if);
        video_addr <= base | 16'h0002;
        @(negedge a2bus_if);
        check_word("video_data_o", video_data, {aux_b[1], main_b[1], aux_b[0], main_b[0]});
        @(posedge a2bus_if);
        video_addr <= {4'h1, r[27:16]};
        @(negedge a2bus_if);
        check_word("video_data_o", video_data, {aux_b[3], main_b[3], aux_b[2], main_b[2]});
        @(posedge a2bus_if);
        @(negedge a2bus_if);
        check_word("video_data_o", video_data, 32'h0000_0000);
    endtask

    task automatic test_keyboard();
        logic [31:0] r;
        a2_data_t    first_key;
        a2_data_t    second_key;
        int          pulses;
        r = next_random();
        first_key = {1'b1, r[6:0]};
        second_key = {1'b1, r[14:8]};
        bus_access(`A2_KBD_ADDR, first_key, 1'b1, 1'b0);
        wait_keypress();
        check_byte("keycode_o", keycode, first_key);
        count_strobes(4, pulses);
        if (pulses != 0) begin
            other_errors++;
            $display("ERROR: keypress strobe pulsed more than once for one key");
        end
        // Ignored while the first key is still pending
        bus_access(`A2_KBD_ADDR, second_key, 1'b1, 1'b0);
        count_strobes(4, pulses);
        if (pulses != 0) begin
            other_errors++;
            $display("ERROR: second key accepted before the strobe was cleared");
        end
        check_byte("keycode_o", keycode, first_key);
        bus_access(`A2_KBD_CLR_ADDR, 8'h00, 1'b1, 1'b0);
        @(negedge a2bus_if);
        check_byte("keycode_o", keycode, {1'b0, first_key[6:0]});
        bus_access(`A2_KBD_ADDR, second_key, 1'b1, 1'b0);
        wait_keypress();
        check_byte("keycode_o", keycode, second_key);
    endtask

    initial begin
        value_errors = 0;
        other_errors = 0;
        lcg_state = 32'hb004_3b71;
        last_aux_mem = 1'b0;
        bus <= idle_bus();
        video_addr <= '0;
        wait_reset_release();
        test_reset_state();
        test_switches();
        clear_switches();
        test_slot_rom();
        test_text();
        test_hires();
        test_keyboard();
        finish_run();
    end

endmodule

// File: verification/apple_memory_props.sv
`timescale 1ns/1ps
`include "apple_mem_settings.svh"

module apple_memory_props (
    input logic                   a2bus_if,
    input logic                   rst_i,
    input apple_mem_pkg::a2_bus_t bus_i,
    input logic                   intc8rom_i,
    input logic                   keypress_strobe_i
);
    import apple_mem_pkg::*;

    logic cfff_access;

    assign cfff_access = bus_i.phi1_posedge && !bus_i.m2sel_n &&
                         (bus_i.addr == `A2_CFFF_ADDR);

    // Keypress strobe is a single cycle pulse
    strobe_single_pulse: assert property (
        @(posedge a2bus_if) disable iff (rst_i)
        keypress_strobe_i |=> !keypress_strobe_i
    ) else $error("keypress strobe stayed high for two cycles");

    // $CFFF always releases the internal $C8 ROM
    cfff_releases_c8rom: assert property (
        @(posedge a2bus_if) disable iff (rst_i)
        cfff_access |=> !intc8rom_i
    ) else $error("intc8rom still set after a $CFFF access");

endmodule

bind apple_memory apple_memory_props props_i (
    .a2bus_if          (a2bus_if),
    .rst_i             (rst_i),
    .bus_i             (bus_i),
    .intc8rom_i        (intc8rom_o),
    .keypress_strobe_i (keypress_strobe_o)
);

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

    // Reset drops on a rising edge, like every other driven input
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: source/apple_memory.sv
`timescale 1ns/1ps

module apple_memory (
    input  logic                    a2bus_if,
    input  logic                    rst_i,
    input  apple_mem_pkg::a2_bus_t  bus_i,
    input  apple_mem_pkg::a2_addr_t video_addr_i,
    output apple_mem_pkg::ram_word_t video_data_o,
    output apple_mem_pkg::sw_ii_t   sw_ii_o,
    output apple_mem_pkg::sw_iie_t  sw_iie_o,
    output apple_mem_pkg::slot_t    slotrom_o,
    output logic                    intc8rom_o,
    output logic                    aux_mem_o,
    output apple_mem_pkg::a2_data_t keycode_o,
    output logic                    keypress_strobe_o
);
    import apple_mem_pkg::*;

    ram_write_t text_wr;
    ram_write_t hires_main_wr;
    ram_write_t hires_aux_wr;
    a2_data_t   wr_byte;

    // ------------------------------
    // Bus watchers
    // ------------------------------

    soft_switches soft_switches_i (
        .a2bus_if   (a2bus_if),
        .rst_i      (rst_i),
        .bus_i      (bus_i),
        .sw_ii_o    (sw_ii_o),
        .sw_iie_o   (sw_iie_o),
        .slotrom_o  (slotrom_o),
        .intc8rom_o (intc8rom_o)
    );

    // Bank choice follows the registered switches
    shadow_write_decode shadow_write_decode_i (
        .bus_i           (bus_i),
        .sw_ii_i         (sw_ii_o),
        .sw_iie_i        (sw_iie_o),
        .aux_mem_o       (aux_mem_o),
        .text_wr_o       (text_wr),
        .hires_main_wr_o (hires_main_wr),
        .hires_aux_wr_o  (hires_aux_wr),
        .wr_byte_o       (wr_byte)
    );

    keyboard_latch keyboard_latch_i (
        .a2bus_if          (a2bus_if),
        .rst_i             (rst_i),
        .bus_i             (bus_i),
        .keycode_o         (keycode_o),
        .keypress_strobe_o (keypress_strobe_o)
    );

    // ------------------------------
    // Shadow memories and scanner
    // ------------------------------

    video_shadow video_shadow_i (
        .a2bus_if        (a2bus_if),
        .rst_i           (rst_i),
        .text_wr_i       (text_wr),
        .hires_main_wr_i (hires_main_wr),
        .hires_aux_wr_i  (hires_aux_wr),
        .wr_byte_i       (wr_byte),
        .video_addr_i    (video_addr_i),
        .video_data_o    (video_data_o)
    );

endmodule

// File: source/keyboard_latch.sv
`timescale 1ns/1ps
`include "apple_mem_settings.svh"

module keyboard_latch (
    input  logic                    a2bus_if,
    input  logic                    rst_i,
    input  apple_mem_pkg::a2_bus_t  bus_i,
    output apple_mem_pkg::a2_data_t keycode_o,
    output logic                    keypress_strobe_o
);
    import apple_mem_pkg::*;

    logic     kbd_read;
    logic     kbd_clear;
    a2_data_t keycode_q;
    logic     strobe_q;

    assign kbd_read  = bus_i.data_in_strobe && bus_i.rw_n && (bus_i.addr == `A2_KBD_ADDR);
    // Clear happens on reads and writes alike
    assign kbd_clear = bus_i.data_in_strobe && (bus_i.addr == `A2_KBD_CLR_ADDR);

    always_ff @(posedge a2bus_if) begin
        if (rst_i) begin
            keycode_q <= '0;
            strobe_q  <= 1'b0;
        end else begin
            strobe_q <= 1'b0;
            if (kbd_read) begin
                // New key only while the previous one is acknowledged
                if (bus_i.data[7] && !keycode_q[7]) begin
                    keycode_q <= bus_i.data;
                    strobe_q  <= 1'b1;
                end
            end else if (kbd_clear) begin
                keycode_q[7] <= 1'b0;
            end
        end
    end

    assign keycode_o         = keycode_q;
    assign keypress_strobe_o = strobe_q;

endmodule

// File: source/video_shadow.sv
`timescale 1ns/1ps
`include "apple_mem_settings.svh"

module video_shadow (
    input  logic                      a2bus_if,
    input  logic                      rst_i,
    input  apple_mem_pkg::ram_write_t text_wr_i,
    input  apple_mem_pkg::ram_write_t hires_main_wr_i,
    input  apple_mem_pkg::ram_write_t hires_aux_wr_i,
    input  apple_mem_pkg::a2_data_t   wr_byte_i,
    input  apple_mem_pkg::a2_addr_t   video_addr_i,
    output apple_mem_pkg::ram_word_t  video_data_o
);
    import apple_mem_pkg::*;

    logic                     text_region;
    logic                     hires_region;
    logic [`TEXT_RAM_AW-1:0]  text_rd_addr;
    logic [`HIRES_RAM_AW-1:0] hires_rd_addr;
    logic                     text_sel_q;
    logic                     hires_sel_q;
    logic                     a1_q;
    ram_word_t                text_data;
    ram_word_t                hires_main_data;
    ram_word_t                hires_aux_data;

    // Aux byte sits above its main partner, highest lane first
    function automatic ram_word_t interleave(input logic hi, input ram_word_t main_w,
                                             input ram_word_t aux_w);
        ram_word_t w;
        if (hi) begin
            w = {aux_w[31:24], main_w[31:24], aux_w[23:16], main_w[23:16]};
        end else begin
            w = {aux_w[15:8], main_w[15:8], aux_w[7:0], main_w[7:0]};
        end
        return w;
    endfunction

    // ------------------------------
    // Scanner address decode
    // ------------------------------

    assign text_region  = (video_addr_i[15:10] == 6'b000001) ||
                          (video_addr_i[15:10] == 6'b000010);
    assign hires_region = (video_addr_i[15:13] == 3'b001) ||
                          (video_addr_i[15:13] == 3'b010);

    // Text word holds two columns for both banks, hires word holds four bytes
    assign text_rd_addr  = {~video_addr_i[10], video_addr_i[9:1]};
    assign hires_rd_addr = {~video_addr_i[13], video_addr_i[12:2]};

    // Selects travel with the registered RAM read
    always_ff @(posedge a2bus_if) begin
        if (rst_i) begin
            text_sel_q  <= 1'b0;
            hires_sel_q <= 1'b0;
            a1_q        <= 1'b0;
        end else begin
            text_sel_q  <= text_region;
            hires_sel_q <= hires_region;
            a1_q        <= video_addr_i[1];
        end
    end

    // ------------------------------
    // Shadow memories
    // ------------------------------

    shadow_ram #(.ADDR_WIDTH(`TEXT_RAM_AW)) text_ram_i (
        .a2bus_if  (a2bus_if),
        .wr_i      (text_wr_i),
        .wr_byte_i (wr_byte_i),
        .rd_addr_i (text_rd_addr),
        .rd_data_o (text_data)
    );

    shadow_ram #(.ADDR_WIDTH(`HIRES_RAM_AW)) hires_main_ram_i (
        .a2bus_if  (a2bus_if),
        .wr_i      (hires_main_wr_i),
        .wr_byte_i (wr_byte_i),
        .rd_addr_i (hires_rd_addr),
        .rd_data_o (hires_main_data)
    );

    shadow_ram #(.ADDR_WIDTH(`HIRES_RAM_AW)) hires_aux_ram_i (
        .a2bus_if  (a2bus_if),
        .wr_i      (hires_aux_wr_i),
        .wr_byte_i (wr_byte_i),
        .rd_addr_i (hires_rd_addr),
        .rd_data_o (hires_aux_data)
    );

    always_comb begin
        if (text_sel_q) begin
            video_data_o = text_data;
        end else if (hires_sel_q) begin
            video_data_o = interleave(a1_q, hires_main_data, hires_aux_data);
        end else begin
            video_data_o = '0;
        end
    end

endmodule

// File: source/shadow_ram.sv
`timescale 1ns/1ps

module shadow_ram #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                      a2bus_if,
    input  apple_mem_pkg::ram_write_t wr_i,
    input  apple_mem_pkg::a2_data_t   wr_byte_i,
    input  logic [ADDR_WIDTH-1:0]     rd_addr_i,
    output apple_mem_pkg::ram_word_t  rd_data_o
);
    import apple_mem_pkg::*;

    ram_word_t             mem [0:(2**ADDR_WIDTH)-1];
    ram_word_t             rd_data_q;
    logic [ADDR_WIDTH-1:0] wr_addr;

    assign wr_addr = wr_i.addr[ADDR_WIDTH-1:0];

    // The same byte is offered on every lane, the enables pick one
    always_ff @(posedge a2bus_if) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (wr_i.enable && wr_i.byte_en[lane]) begin
                mem[wr_addr][lane*8 +: 8] <= wr_byte_i;
            end
        end
    end

    always_ff @(posedge a2bus_if) begin
        rd_data_q <= mem[rd_addr_i];
    end

    assign rd_data_o = rd_data_q;

endmodule

// File: source/shadow_write_decode.sv
`timescale 1ns/1ps

module shadow_write_decode (
    input  apple_mem_pkg::a2_bus_t    bus_i,
    input  apple_mem_pkg::sw_ii_t     sw_ii_i,
    input  apple_mem_pkg::sw_iie_t    sw_iie_i,
    output logic                      aux_mem_o,
    output apple_mem_pkg::ram_write_t text_wr_o,
    output apple_mem_pkg::ram_write_t hires_main_wr_o,
    output apple_mem_pkg::ram_write_t hires_aux_wr_o,
    output apple_mem_pkg::a2_data_t   wr_byte_o
);
    import apple_mem_pkg::*;

    logic        write_strobe;
    logic        cpu_write;
    logic        aux_mem;
    logic        e1;
    logic        text_range;
    logic        hires_range;
    logic [11:0] text_offset;
    logic [13:0] hires_offset;

    // One-hot lane enable from the low two offset bits
    function automatic byte_en_t lane_enable(input logic [1:0] lane);
        byte_en_t be;
        be = '0;
        be[lane] = 1'b1;
        return be;
    endfunction

    assign write_strobe = bus_i.data_in_strobe && !bus_i.rw_n;
    assign cpu_write    = !bus_i.rw_n;

    // ------------------------------
    // Main or aux bank
    // ------------------------------

    always_comb begin
        if ((bus_i.addr[15:9] == 7'b0000000) || (bus_i.addr[15:14] == 2'b11)) begin
            // Zero page, stack and the language card area
            aux_mem = sw_iie_i.altzp;
        end else if (bus_i.addr[15:10] == 6'b000001) begin
            // Text page 1
            aux_mem = (sw_iie_i.store80 && sw_ii_i.page2) ||
                      (!sw_iie_i.store80 && sw_iie_i.ramwrt && cpu_write);
        end else if (bus_i.addr[15:13] == 3'b001) begin
            // Hires page 1
            aux_mem = (sw_iie_i.store80 && sw_ii_i.page2 && sw_ii_i.hires_mode) ||
                      ((!sw_iie_i.store80 || !sw_ii_i.hires_mode) &&
                       sw_iie_i.ramwrt && cpu_write);
        end else begin
            aux_mem = sw_iie_i.ramwrt && cpu_write;
        end
    end

    assign aux_mem_o = aux_mem;
    assign e1        = aux_mem || bus_i.m2b0;

    // ------------------------------
    // Ranges and offsets
    // ------------------------------

    // $0400-$0BFF and $2000-$5FFF
    assign text_range  = (bus_i.addr[15:10] == 6'b000001) || (bus_i.addr[15:10] == 6'b000010);
    assign hires_range = (bus_i.addr[15:13] == 3'b001) || (bus_i.addr[15:13] == 3'b010);

    // Text bytes interleave main and aux, so the bank is the lowest offset bit
    assign text_offset  = {~bus_i.addr[10], bus_i.addr[9:0], e1};
    assign hires_offset = 14'(bus_i.addr - 16'h2000);

    always_comb begin
        text_wr_o.enable  = write_strobe && text_range;
        text_wr_o.addr    = {2'b00, text_offset[11:2]};
        text_wr_o.byte_en = lane_enable(text_offset[1:0]);

        hires_main_wr_o.enable  = write_strobe && hires_range && !e1;
        hires_main_wr_o.addr    = hires_offset[13:2];
        hires_main_wr_o.byte_en = lane_enable(hires_offset[1:0]);

        hires_aux_wr_o.enable  = write_strobe && hires_range && e1;
        hires_aux_wr_o.addr    = hires_offset[13:2];
        hires_aux_wr_o.byte_en = lane_enable(hires_offset[1:0]);
    end

    assign wr_byte_o = bus_i.data;

endmodule

// File: source/soft_switches.sv
`timescale 1ns/1ps
`include "apple_mem_settings.svh"

module soft_switches (
    input  logic                   a2bus_if,
    input  logic                   rst_i,
    input  apple_mem_pkg::a2_bus_t bus_i,
    output apple_mem_pkg::sw_ii_t  sw_ii_o,
    output apple_mem_pkg::sw_iie_t sw_iie_o,
    output apple_mem_pkg::slot_t   slotrom_o,
    output logic                   intc8rom_o
);
    import apple_mem_pkg::*;

    logic       bus_cycle;
    logic       ii_access;
    logic       iie_write;
    logic       state_write;
    logic       cfff_access;
    logic       slot_access;
    logic       c3_access;
    logic [7:0] sw_ii_bits;
    logic [7:0] sw_iie_bits;
    sw_ii_t     sw_ii_q;
    sw_ii_t     sw_ii_d;
    sw_iie_t    sw_iie_q;
    sw_iie_t    sw_iie_d;
    slot_t      slotrom_q;
    logic       intc8rom_q;

    // ------------------------------
    // Address decode
    // ------------------------------

    // Switches are sampled once per bus cycle, on the phi1 edge
    assign bus_cycle   = bus_i.phi1_posedge && !bus_i.m2sel_n;
    assign ii_access   = bus_cycle && (bus_i.addr[15:4] == `A2_SW_II_PAGE);
    assign iie_write   = bus_cycle && !bus_i.rw_n && (bus_i.addr[15:4] == `A2_SW_IIE_PAGE);
    assign state_write = bus_cycle && !bus_i.rw_n && (bus_i.addr == `A2_STATE_ADDR);
    assign cfff_access = bus_cycle && (bus_i.addr == `A2_CFFF_ADDR);
    // $C100 to $C7FF
    assign slot_access = bus_cycle && (bus_i.addr[15:11] == 5'b11000) &&
                         (bus_i.addr[10:8] != 3'd0);
    assign c3_access   = (bus_i.addr[15:8] == 8'hC3);

    // ------------------------------
    // Switch next state
    // ------------------------------

    always_comb begin
        sw_ii_bits = sw_ii_q;
        sw_ii_bits[bus_i.addr[3:1]] = bus_i.addr[0];
        sw_ii_d = sw_ii_q;
        if (ii_access) begin
            sw_ii_d = sw_ii_t'(sw_ii_bits);
        end else if (state_write) begin
            sw_ii_d.page2 = bus_i.data[6];
        end
    end

    always_comb begin
        sw_iie_bits = sw_iie_q;
        sw_iie_bits[bus_i.addr[3:1]] = bus_i.addr[0];
        sw_iie_d = sw_iie_q;
        if (iie_write) begin
            sw_iie_d = sw_iie_t'(sw_iie_bits);
        end else if (state_write) begin
            // State register carries the memory paging bits
            sw_iie_d.ramrd    = bus_i.data[5];
            sw_iie_d.ramwrt   = bus_i.data[4];
            sw_iie_d.intcxrom = bus_i.data[0];
        end
    end

    always_ff @(posedge a2bus_if) begin
        if (rst_i) begin
            sw_ii_q  <= sw_ii_t'(`SW_II_RESET);
            sw_iie_q <= '0;
        end else begin
            sw_ii_q  <= sw_ii_d;
            sw_iie_q <= sw_iie_d;
        end
    end

    // ------------------------------
    // Slot ROM and $C8 ROM
    // ------------------------------

    always_ff @(posedge a2bus_if) begin
        if (rst_i) begin
            slotrom_q  <= '0;
            intc8rom_q <= 1'b0;
        end else if (cfff_access) begin
            slotrom_q  <= '0;
            intc8rom_q <= 1'b0;
        end else if (slot_access) begin
            slotrom_q <= bus_i.addr[10:8];
            // Slot 3 maps the internal firmware when its slot ROM is off
            if (c3_access && !sw_iie_q.slotc3rom) begin
                intc8rom_q <= 1'b1;
            end
        end
    end

    assign sw_ii_o    = sw_ii_q;
    assign sw_iie_o   = sw_iie_q;
    assign slotrom_o  = slotrom_q;
    assign intc8rom_o = intc8rom_q;

endmodule

// File: source/apple_mem_pkg.sv
`include "apple_mem_settings.svh"

package apple_mem_pkg;

    // Plain vectors with a fixed meaning
    typedef logic [15:0] a2_addr_t;
    typedef logic [7:0]  a2_data_t;
    typedef logic [31:0] ram_word_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [2:0]  slot_t;

    // One clock's view of the Apple II bus
    typedef struct packed {
        a2_addr_t addr;
        a2_data_t data;
        logic     rw_n;
        logic     data_in_strobe;
        logic     phi1_posedge;
        logic     m2sel_n;
        logic     m2b0;
    } a2_bus_t;

    // Bit n is the switch selected by addr[3:1] == n at $C05x
    typedef struct packed {
        logic an3;
        logic an2;
        logic an1;
        logic an0;
        logic hires_mode;
        logic page2;
        logic mixed_mode;
        logic text_mode;
    } sw_ii_t;

    // Same bit order for the IIe switches at $C00x
    typedef struct packed {
        logic altchar;
        logic col80;
        logic slotc3rom;
        logic altzp;
        logic intcxrom;
        logic ramwrt;
        logic ramrd;
        logic store80;
    } sw_iie_t;

    // Write request for one shadow RAM, narrower RAMs use the low address bits
    typedef struct packed {
        logic                     enable;
        logic [`HIRES_RAM_AW-1:0] addr;
        byte_en_t                 byte_en;
    } ram_write_t;

endpackage

// File: source/apple_mem_settings.svh
`ifndef APPLE_MEM_SETTINGS_SVH
`define APPLE_MEM_SETTINGS_SVH

// Soft switch pages, compared against addr[15:4]
`define A2_SW_II_PAGE    12'hC05
`define A2_SW_IIE_PAGE   12'hC00

// Single address registers and strobes
`define A2_STATE_ADDR    16'hC068
`define A2_CFFF_ADDR     16'hCFFF
`define A2_KBD_ADDR      16'hC000
`define A2_KBD_CLR_ADDR  16'hC010

// Word address widths of the shadow RAMs
`define TEXT_RAM_AW      10
`define HIRES_RAM_AW     12

// TEXT_MODE in bit 0 and AN3 in bit 7
`define SW_II_RESET      8'h81

`endif
